// File: source/rv_pkg.sv
package rv_pkg;

//////////////////////////////////////////////////////////////
// sizes
//////////////////////////////////////////////////////////////
localparam int XLEN      = 32;
localparam int WADDR_W   = 14;
localparam int RAM_WORDS = 16384;

// only system instruction the core knows
localparam logic [XLEN-1:0] EBREAK_INSN = 32'h0010_0073;

typedef logic [XLEN-1:0]    word_t;
typedef logic [WADDR_W-1:0] waddr_t;
typedef logic [4:0]         reg_idx_t;

//////////////////////////////////////////////////////////////
// control encodings
//////////////////////////////////////////////////////////////
typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
} alu_fun_t;

typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE
} br_fun_t;

typedef enum logic {
    OP1_RS1,
    OP1_PC
} op1_sel_t;

typedef enum logic [1:0] {
    OP2_RS2,
    OP2_IMM_I,
    OP2_IMM_S,
    OP2_IMM_U
} op2_sel_t;

typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
} wb_sel_t;

typedef enum logic [1:0] {
    PC_PLUS4,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
} pc_sel_t;

// host side of the memory arbiter
typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ACK,
    ARB_RELEASE
} arb_state_t;

endpackage

// File: source/word_ram.sv
module word_ram (
    input  logic           clk,
    input  logic           i_we,
    input  rv_pkg::waddr_t i_addr,
    input  rv_pkg::word_t  i_wdata,
    output rv_pkg::word_t  o_rdata
);

rv_pkg::word_t mem [rv_pkg::RAM_WORDS];

always_ff @(posedge clk) begin
    if (i_we) begin
        mem[i_addr] <= i_wdata;
    end
end

// asynchronous read
assign o_rdata = mem[i_addr];

endmodule

// File: source/rv_decode.sv
module rv_decode (
    input  rv_pkg::word_t    i_insn,
    output rv_pkg::reg_idx_t o_rs1,
    output rv_pkg::reg_idx_t o_rs2,
    output rv_pkg::reg_idx_t o_rd,
    output rv_pkg::alu_fun_t o_alu_fun,
    output rv_pkg::br_fun_t  o_br_fun,
    output rv_pkg::op1_sel_t o_op1_sel,
    output rv_pkg::op2_sel_t o_op2_sel,
    output rv_pkg::wb_sel_t  o_wb_sel,
    output rv_pkg::pc_sel_t  o_pc_sel,
    output logic             o_rf_we,
    output logic             o_store,
    output logic             o_load,
    output logic             o_ebreak,
    output rv_pkg::word_t    o_imm
);

localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;

logic [6:0]    opcode;
logic [2:0]    funct3;
logic [6:0]    funct7;
rv_pkg::word_t imm_i;
rv_pkg::word_t imm_s;
rv_pkg::word_t imm_b;
rv_pkg::word_t imm_u;
rv_pkg::word_t imm_j;

assign opcode = i_insn[6:0];
assign funct3 = i_insn[14:12];
assign funct7 = i_insn[31:25];

// sign-extended immediates, one per format
assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
assign imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
assign imm_u = {i_insn[31:12], 12'b0};
assign imm_j = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};

assign o_rs2    = i_insn[24:20];
assign o_rd     = i_insn[11:7];
assign o_ebreak = (i_insn == rv_pkg::EBREAK_INSN);

always_comb begin
    // defaults give a no-op with no writes
    o_rs1     = i_insn[19:15];
    o_alu_fun = rv_pkg::ALU_ADD;
    o_br_fun  = rv_pkg::BR_NONE;
    o_op1_sel = rv_pkg::OP1_RS1;
    o_op2_sel = rv_pkg::OP2_RS2;
    o_wb_sel  = rv_pkg::WB_ALU;
    o_pc_sel  = rv_pkg::PC_PLUS4;
    o_rf_we   = 1'b0;
    o_store   = 1'b0;
    o_load    = 1'b0;
    o_imm     = '0;

    case (opcode)
        OPC_OP: begin
            o_rf_we = (funct7 == 7'b0000000);
            case (funct3)
                3'b000: begin
                    if (funct7 == 7'b0100000) begin
                        o_alu_fun = rv_pkg::ALU_SUB;
                        o_rf_we   = 1'b1;
                    end
                end
                3'b010: o_alu_fun = rv_pkg::ALU_SLT;
                3'b100: o_alu_fun = rv_pkg::ALU_XOR;
                3'b110: o_alu_fun = rv_pkg::ALU_OR;
                3'b111: o_alu_fun = rv_pkg::ALU_AND;
                default: o_rf_we = 1'b0;
            endcase
        end
        OPC_OP_IMM: begin
            // addi only
            if (funct3 == 3'b000) begin
                o_op2_sel = rv_pkg::OP2_IMM_I;
                o_imm     = imm_i;
                o_rf_we   = 1'b1;
            end
        end
        OPC_LUI: begin
            // x0 + imm
            o_rs1     = '0;
            o_op2_sel = rv_pkg::OP2_IMM_U;
            o_imm     = imm_u;
            o_rf_we   = 1'b1;
        end
        OPC_LOAD: begin
            if (funct3 == 3'b010) begin
                o_op2_sel = rv_pkg::OP2_IMM_I;
                o_imm     = imm_i;
                o_wb_sel  = rv_pkg::WB_MEM;
                o_load    = 1'b1;
                o_rf_we   = 1'b1;
            end
        end
        OPC_STORE: begin
            if (funct3 == 3'b010) begin
                o_op2_sel = rv_pkg::OP2_IMM_S;
                o_imm     = imm_s;
                o_store   = 1'b1;
            end
        end
        OPC_BRANCH: begin
            // target comes out of the alu as pc + imm
            if (funct3[2:1] == 2'b00) begin
                o_br_fun  = funct3[0] ? rv_pkg::BR_NE : rv_pkg::BR_EQ;
                o_op1_sel = rv_pkg::OP1_PC;
                o_op2_sel = rv_pkg::OP2_IMM_I;
                o_imm     = imm_b;
                o_pc_sel  = rv_pkg::PC_BRANCH;
            end
        end
        OPC_JAL: begin
            o_op1_sel = rv_pkg::OP1_PC;
            o_op2_sel = rv_pkg::OP2_IMM_I;
            o_imm     = imm_j;
            o_pc_sel  = rv_pkg::PC_JAL;
            o_wb_sel  = rv_pkg::WB_PC4;
            o_rf_we   = 1'b1;
        end
        OPC_JALR: begin
            if (funct3 == 3'b000) begin
                o_op2_sel = rv_pkg::OP2_IMM_I;
                o_imm     = imm_i;
                o_pc_sel  = rv_pkg::PC_JALR;
                o_wb_sel  = rv_pkg::WB_PC4;
                o_rf_we   = 1'b1;
            end
        end
        default: ;
    endcase
end

endmodule

// File: source/rv_regfile.sv
module rv_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t i_ra1,
    input  rv_pkg::reg_idx_t i_ra2,
    input  rv_pkg::reg_idx_t i_wa,
    input  logic             i_we,
    input  rv_pkg::word_t    i_wd,
    output rv_pkg::word_t    o_rd1,
    output rv_pkg::word_t    o_rd2
);

rv_pkg::word_t regs [32];

always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (i_we && (i_wa != '0)) begin
        regs[i_wa] <= i_wd;
    end
end

// x0 is hardwired
assign o_rd1 = (i_ra1 == '0) ? '0 : regs[i_ra1];
assign o_rd2 = (i_ra2 == '0) ? '0 : regs[i_ra2];

endmodule

// File: source/rv_execute.sv
module rv_execute (
    input  rv_pkg::word_t    i_a,
    input  rv_pkg::word_t    i_b,
    input  rv_pkg::word_t    i_rs1,
    input  rv_pkg::word_t    i_rs2,
    input  rv_pkg::alu_fun_t i_alu_fun,
    input  rv_pkg::br_fun_t  i_br_fun,
    output rv_pkg::word_t    o_result,
    output logic             o_taken
);

logic less;
logic equal;

assign less  = ($signed(i_a) < $signed(i_b));
assign equal = (i_rs1 == i_rs2);

//////////////////////////////////////////////////////////////
// alu
//////////////////////////////////////////////////////////////
always_comb begin
    case (i_alu_fun)
        rv_pkg::ALU_SUB: o_result = i_a - i_b;
        rv_pkg::ALU_AND: o_result = i_a & i_b;
        rv_pkg::ALU_OR:  o_result = i_a | i_b;
        rv_pkg::ALU_XOR: o_result = i_a ^ i_b;
        rv_pkg::ALU_SLT: o_result = {{(rv_pkg::XLEN-1){1'b0}}, less};
        default:         o_result = i_a + i_b;
    endcase
end

//////////////////////////////////////////////////////////////
// branch compare, always on the register values
//////////////////////////////////////////////////////////////
always_comb begin
    case (i_br_fun)
        rv_pkg::BR_EQ: o_taken = equal;
        rv_pkg::BR_NE: o_taken = !equal;
        default:       o_taken = 1'b0;
    endcase
end

endmodule

// File: source/rv_core.sv
module rv_core (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_run,
    output rv_pkg::waddr_t o_iaddr,
    input  rv_pkg::word_t  i_insn,
    output logic           o_dmem_en,
    output logic           o_dmem_we,
    output rv_pkg::waddr_t o_daddr,
    output rv_pkg::word_t  o_dwdata,
    input  rv_pkg::word_t  i_drdata,
    output logic           o_halted
);

rv_pkg::word_t    pc;
rv_pkg::word_t    pc_next;
rv_pkg::word_t    pc_plus4;
logic             run_ok;

rv_pkg::reg_idx_t rs1_idx;
rv_pkg::reg_idx_t rs2_idx;
rv_pkg::reg_idx_t rd_idx;
rv_pkg::alu_fun_t alu_fun;
rv_pkg::br_fun_t  br_fun;
rv_pkg::op1_sel_t op1_sel;
rv_pkg::op2_sel_t op2_sel;
rv_pkg::wb_sel_t  wb_sel;
rv_pkg::pc_sel_t  pc_sel;
logic             dec_rf_we;
logic             dec_store;
logic             dec_load;
logic             dec_ebreak;
rv_pkg::word_t    imm;

rv_pkg::word_t    rd1;
rv_pkg::word_t    rd2;
rv_pkg::word_t    op_a;
rv_pkg::word_t    op_b;
rv_pkg::word_t    alu_out;
rv_pkg::word_t    wb_data;
logic             taken;

// one instruction retires per edge while this is high
assign o_halted = i_run && dec_ebreak;
assign run_ok   = i_run && !o_halted;

//////////////////////////////////////////////////////////////
// program counter
//////////////////////////////////////////////////////////////
assign pc_plus4 = pc + 32'd4;

always_comb begin
    case (pc_sel)
        rv_pkg::PC_BRANCH: pc_next = taken ? alu_out : pc_plus4;
        rv_pkg::PC_JAL:    pc_next = alu_out;
        rv_pkg::PC_JALR:   pc_next = {alu_out[31:1], 1'b0};
        default:           pc_next = pc_plus4;
    endcase
end

always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
        pc <= '0;
    end else if (run_ok) begin
        pc <= pc_next;
    end
end

assign o_iaddr = pc[rv_pkg::WADDR_W+1:2];

rv_decode u_decode (
    .i_insn    (i_insn),
    .o_rs1     (rs1_idx),
    .o_rs2     (rs2_idx),
    .o_rd      (rd_idx),
    .o_alu_fun (alu_fun),
    .o_br_fun  (br_fun),
    .o_op1_sel (op1_sel),
    .o_op2_sel (op2_sel),
    .o_wb_sel  (wb_sel),
    .o_pc_sel  (pc_sel),
    .o_rf_we   (dec_rf_we),
    .o_store   (dec_store),
    .o_load    (dec_load),
    .o_ebreak  (dec_ebreak),
    .o_imm     (imm)
);

rv_regfile u_regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .i_ra1 (rs1_idx),
    .i_ra2 (rs2_idx),
    .i_wa  (rd_idx),
    .i_we  (dec_rf_we && run_ok),
    .i_wd  (wb_data),
    .o_rd1 (rd1),
    .o_rd2 (rd2)
);

//////////////////////////////////////////////////////////////
// operands and execute
//////////////////////////////////////////////////////////////
assign op_a = (op1_sel == rv_pkg::OP1_PC) ? pc : rd1;

// decoder already picked the immediate for the format
always_comb begin
    case (op2_sel)
        rv_pkg::OP2_IMM_I,
        rv_pkg::OP2_IMM_S,
        rv_pkg::OP2_IMM_U: op_b = imm;
        default:           op_b = rd2;
    endcase
end

rv_execute u_execute (
    .i_a       (op_a),
    .i_b       (op_b),
    .i_rs1     (rd1),
    .i_rs2     (rd2),
    .i_alu_fun (alu_fun),
    .i_br_fun  (br_fun),
    .o_result  (alu_out),
    .o_taken   (taken)
);

// data memory, word addressed
assign o_dmem_en = (dec_load || dec_store) && run_ok;
assign o_dmem_we = dec_store && run_ok;
assign o_daddr   = alu_out[rv_pkg::WADDR_W+1:2];
assign o_dwdata  = rd2;

always_comb begin
    case (wb_sel)
        rv_pkg::WB_MEM: wb_data = i_drdata;
        rv_pkg::WB_PC4: wb_data = pc_plus4;
        default:        wb_data = alu_out;
    endcase
end

endmodule

// File: source/mem_arbiter.sv
module mem_arbiter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_core_fetching,
    input  logic           i_core_en,
    input  logic           i_core_we,
    input  rv_pkg::waddr_t i_core_addr,
    input  rv_pkg::word_t  i_core_wdata,
    output rv_pkg::word_t  o_core_rdata,
    input  logic           i_host_req,
    input  logic           i_host_we,
    input  logic           i_host_imem,
    input  rv_pkg::waddr_t i_host_addr,
    input  rv_pkg::word_t  i_host_wdata,
    output logic           o_host_ack,
    output rv_pkg::word_t  o_host_rdata,
    output logic           o_dram_we,
    output rv_pkg::waddr_t o_dram_addr,
    output rv_pkg::word_t  o_dram_wdata,
    input  rv_pkg::word_t  i_dram_rdata,
    output logic           o_iram_we,
    output rv_pkg::waddr_t o_iram_addr,
    output rv_pkg::word_t  o_iram_wdata,
    input  rv_pkg::word_t  i_iram_rdata,
    input  rv_pkg::waddr_t i_core_iaddr,
    output rv_pkg::word_t  o_core_insn
);

rv_pkg::arb_state_t state;
rv_pkg::arb_state_t state_next;
logic               host_pending;
logic               host_dram;
logic               host_iram;
logic               grant;

//////////////////////////////////////////////////////////////
// ownership, core first
//////////////////////////////////////////////////////////////
assign host_pending = (state == rv_pkg::ARB_IDLE) && i_host_req;
assign host_dram    = host_pending && !i_host_imem && !i_core_en;
assign host_iram    = host_pending && i_host_imem && !i_core_fetching;
assign grant        = host_dram || host_iram;

assign o_dram_addr  = i_core_en ? i_core_addr : i_host_addr;
assign o_dram_wdata = i_core_en ? i_core_wdata : i_host_wdata;
assign o_dram_we    = i_core_en ? i_core_we : (host_dram && i_host_we);
assign o_core_rdata = i_dram_rdata;

assign o_iram_addr  = host_iram ? i_host_addr : i_core_iaddr;
assign o_iram_wdata = i_host_wdata;
assign o_iram_we    = host_iram && i_host_we;

// a halted core keeps seeing ebreak while the host borrows the RAM
assign o_core_insn  = host_iram ? rv_pkg::EBREAK_INSN : i_iram_rdata;

//////////////////////////////////////////////////////////////
// host handshake
//////////////////////////////////////////////////////////////
always_comb begin
    state_next = state;
    case (state)
        rv_pkg::ARB_IDLE:    if (grant) state_next = rv_pkg::ARB_ACK;
        rv_pkg::ARB_ACK:     if (!i_host_req) state_next = rv_pkg::ARB_RELEASE;
        rv_pkg::ARB_RELEASE: state_next = rv_pkg::ARB_IDLE;
        default:             state_next = rv_pkg::ARB_IDLE;
    endcase
end

always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
        state <= rv_pkg::ARB_IDLE;
    end else begin
        state <= state_next;
    end
end

assign o_host_ack = (state == rv_pkg::ARB_ACK);

// read data captured in the access cycle
always_ff @(posedge clk) begin
    if (grant) begin
        o_host_rdata <= i_host_imem ? i_iram_rdata : i_dram_rdata;
    end
end

endmodule

// File: source/rv_soc.sv
module rv_soc (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_run,
    output logic           o_halted,
    input  logic           i_host_req,
    input  logic           i_host_we,
    input  logic           i_host_imem,
    input  rv_pkg::waddr_t i_host_addr,
    input  rv_pkg::word_t  i_host_wdata,
    output logic           o_host_ack,
    output rv_pkg::word_t  o_host_rdata
);

// core side
rv_pkg::waddr_t core_iaddr;
rv_pkg::word_t  core_insn;
logic           core_den;
logic           core_dwe;
rv_pkg::waddr_t core_daddr;
rv_pkg::word_t  core_dwdata;
rv_pkg::word_t  core_drdata;

// ram side
logic           iram_we;
rv_pkg::waddr_t iram_addr;
rv_pkg::word_t  iram_wdata;
rv_pkg::word_t  iram_rdata;
logic           dram_we;
rv_pkg::waddr_t dram_addr;
rv_pkg::word_t  dram_wdata;
rv_pkg::word_t  dram_rdata;

rv_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_run     (i_run),
    .o_iaddr   (core_iaddr),
    .i_insn    (core_insn),
    .o_dmem_en (core_den),
    .o_dmem_we (core_dwe),
    .o_daddr   (core_daddr),
    .o_dwdata  (core_dwdata),
    .i_drdata  (core_drdata),
    .o_halted  (o_halted)
);

mem_arbiter u_arbiter (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_core_fetching (i_run && !o_halted),
    .i_core_en       (core_den),
    .i_core_we       (core_dwe),
    .i_core_addr     (core_daddr),
    .i_core_wdata    (core_dwdata),
    .o_core_rdata    (core_drdata),
    .i_host_req      (i_host_req),
    .i_host_we       (i_host_we),
    .i_host_imem     (i_host_imem),
    .i_host_addr     (i_host_addr),
    .i_host_wdata    (i_host_wdata),
    .o_host_ack      (o_host_ack),
    .o_host_rdata    (o_host_rdata),
    .o_dram_we       (dram_we),
    .o_dram_addr     (dram_addr),
    .o_dram_wdata    (dram_wdata),
    .i_dram_rdata    (dram_rdata),
    .o_iram_we       (iram_we),
    .o_iram_addr     (iram_addr),
    .o_iram_wdata    (iram_wdata),
    .i_iram_rdata    (iram_rdata),
    .i_core_iaddr    (core_iaddr),
    .o_core_insn     (core_insn)
);

word_ram u_imem (
    .clk     (clk),
    .i_we    (iram_we),
    .i_addr  (iram_addr),
    .i_wdata (iram_wdata),
    .o_rdata (iram_rdata)
);

word_ram u_dmem (
    .clk     (clk),
    .i_we    (dram_we),
    .i_addr  (dram_addr),
    .i_wdata (dram_wdata),
    .o_rdata (dram_rdata)
);

endmodule

// File: verification/tb_rv_soc.sv
module tb_rv_soc;

localparam int          N_PROGRAMS   = 8;
localparam int          MAX_WORDS    = 512;
localparam int          BODY_OPS     = 100;
localparam int          ACK_LIMIT    = 1000;
localparam int          RUN_LIMIT    = 2000;
localparam int          HOST_READS   = 12;
localparam int          RESULT_WORD  = 256;
localparam int          CONTEND_WORD = 1000;
localparam logic [31:0] SEED         = 32'h2729_f855;
localparam int          WATCHDOG     = N_PROGRAMS * MAX_WORDS * 4 * 10;

logic           clk;
logic           rst_n;
logic           i_run;
logic           o_halted;
logic           i_host_req;
logic           i_host_we;
logic           i_host_imem;
rv_pkg::waddr_t i_host_addr;
rv_pkg::word_t  i_host_wdata;
logic           o_host_ack;
rv_pkg::word_t  o_host_rdata;

logic [31:0]    lfsr;
rv_pkg::word_t  prog [$];
rv_pkg::word_t  model_regs [32];
rv_pkg::word_t  model_dmem [rv_pkg::RAM_WORDS];

rv_soc DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_run        (i_run),
    .o_halted     (o_halted),
    .i_host_req   (i_host_req),
    .i_host_we    (i_host_we),
    .i_host_imem  (i_host_imem),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .o_host_ack   (o_host_ack),
    .o_host_rdata (o_host_rdata)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

initial begin
    #(WATCHDOG);
    $display("watchdog expired, the run took far longer than the tests need");
    $display("Some tests failed");
    $fatal(1);
end

//////////////////////////////////////////////////////////////
// random numbers and checking
//////////////////////////////////////////////////////////////

// fibonacci lfsr with taps 32 22 2 1 and one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        r    = {r[30:0], fb};
    end
    return r;
endfunction

task automatic check_word(input string name, input rv_pkg::word_t got,
                          input rv_pkg::word_t exp);
    assert (got === exp) else begin
        $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("Some tests failed");
        $fatal(1);
    end
endtask

//////////////////////////////////////////////////////////////
// instruction encoders
//////////////////////////////////////////////////////////////
function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                        input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                        input rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                        input rv_pkg::reg_idx_t rd, input logic [6:0] opc);
    return {imm, rs1, 3'b000, rd, opc};
endfunction

function automatic rv_pkg::word_t enc_lw(input logic [11:0] imm, input rv_pkg::reg_idx_t rd);
    return {imm, 5'd0, 3'b010, rd, 7'b0000011};
endfunction

// store word with base x0
function automatic rv_pkg::word_t enc_sw(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input rv_pkg::reg_idx_t rs2,
                                        input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

//////////////////////////////////////////////////////////////
// program generation
//////////////////////////////////////////////////////////////
task automatic add_alu_op();
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    logic [2:0]       op;
    rd  = 5'(rand_bits(5));
    rs1 = 5'(rand_bits(5));
    rs2 = 5'(rand_bits(5));
    op  = 3'(rand_bits(3));
    case (op)
        3'd0:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b000, rd));
        3'd1:    prog.push_back(enc_r(7'h20, rs2, rs1, 3'b000, rd));
        3'd2:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b111, rd));
        3'd3:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b110, rd));
        3'd4:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b100, rd));
        3'd5:    prog.push_back(enc_r(7'h00, rs2, rs1, 3'b010, rd));
        3'd6:    prog.push_back(enc_i(12'(rand_bits(12)), rs1, rd, 7'b0010011));
        default: prog.push_back({20'(rand_bits(20)), rd, 7'b0110111});
    endcase
endtask

// loads and stores stay inside the 64-word seed area
task automatic add_mem_op();
    rv_pkg::reg_idx_t r;
    logic [11:0]      offs;
    r    = 5'(rand_bits(5));
    offs = {4'b0, 6'(rand_bits(6)), 2'b00};
    if (rand_bits(1) == 1) begin
        prog.push_back(enc_sw(offs, r));
    end else begin
        prog.push_back(enc_lw(offs, r));
    end
endtask

// every flow item jumps over exactly one addi
task automatic add_flow_op();
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rt;
    logic [1:0]       kind;
    logic [11:0]      target;
    rd   = 5'(rand_bits(5));
    rs1  = 5'(rand_bits(5));
    rs2  = (rand_bits(1) == 1) ? rs1 : 5'(rand_bits(5));
    rt   = 5'(rand_bits(5)) | 5'd1;
    kind = 2'(rand_bits(2));
    case (kind)
        2'd0:    prog.push_back(enc_b(13'd8, rs2, rs1, 3'b000));
        2'd1:    prog.push_back(enc_b(13'd8, rs2, rs1, 3'b001));
        2'd2:    prog.push_back(enc_j(21'd8, rd));
        default: begin
            // absolute target that sometimes has bit 0 set
            target = 12'((prog.size() + 1) * 4 + 8) | 12'(rand_bits(1));
            prog.push_back(enc_i(target, 5'd0, rt, 7'b0010011));
            prog.push_back(enc_i(12'd0, rt, rd, 7'b1100111));
        end
    endcase
    rd = 5'(rand_bits(5));
    prog.push_back(enc_i(12'(rand_bits(12)), rd, rd, 7'b0010011));
endtask

task automatic build_program(input int kind);
    prog.delete();
    for (int i = 0; i < BODY_OPS; i++) begin
        case (kind)
            0:       add_alu_op();
            1: begin
                if (rand_bits(2) == 0) add_mem_op();
                else add_alu_op();
            end
            2: begin
                if (rand_bits(1) == 1) add_flow_op();
                else add_alu_op();
            end
            default: begin
                if (rand_bits(2) != 0) add_mem_op();
                else add_alu_op();
            end
        endcase
    end
    if (kind == 1) begin
        // writes aimed at x0
        prog.push_back(enc_i(12'h055, 5'd1, 5'd0, 7'b0010011));
        prog.push_back(enc_lw(12'd12, 5'd0));
    end
    for (int r = 0; r < 32; r++) begin
        prog.push_back(enc_sw(12'(RESULT_WORD * 4 + r * 4), 5'(r)));
    end
    prog.push_back(rv_pkg::EBREAK_INSN);
endtask

//////////////////////////////////////////////////////////////
// ISA reference model
//////////////////////////////////////////////////////////////
task automatic run_model();
    rv_pkg::word_t pc;
    rv_pkg::word_t insn;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t ea;
    rv_pkg::word_t res;
    rv_pkg::word_t nxt;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_j;
    logic          wr;
    logic          done;
    int            steps;
    for (int r = 0; r < 32; r++) begin
        model_regs[r] = '0;
    end
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < RUN_LIMIT) begin
        insn = prog[pc >> 2];
        if (insn == rv_pkg::EBREAK_INSN) begin
            done = 1'b1;
        end else begin
            a     = model_regs[insn[19:15]];
            b     = model_regs[insn[24:20]];
            imm_i = {{20{insn[31]}}, insn[31:20]};
            imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
            wr    = 1'b1;
            res   = '0;
            nxt   = pc + 4;
            case (insn[6:0])
                7'b0110011: begin
                    case ({insn[30], insn[14:12]})
                        4'b0000: res = a + b;
                        4'b1000: res = a - b;
                        4'b0010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        4'b0100: res = a ^ b;
                        4'b0110: res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'b0010011: res = a + imm_i;
                7'b0110111: res = {insn[31:12], 12'b0};
                7'b0000011: begin
                    ea  = a + imm_i;
                    res = model_dmem[ea[15:2]];
                end
                7'b0100011: begin
                    wr = 1'b0;
                    ea = a + imm_s;
                    model_dmem[ea[15:2]] = b;
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if (insn[12] ? (a != b) : (a == b)) nxt = pc + imm_b;
                end
                7'b1101111: begin
                    res = pc + 4;
                    nxt = pc + imm_j;
                end
                7'b1100111: begin
                    res = pc + 4;
                    ea  = a + imm_i;
                    nxt = {ea[31:1], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && insn[11:7] != 5'd0) model_regs[insn[11:7]] = res;
            pc = nxt;
            steps++;
        end
    end
    assert (done) else begin
        $display("reference model never reached ebreak");
        $display("Some tests failed");
        $fatal(1);
    end
endtask

//////////////////////////////////////////////////////////////
// DUT access
//////////////////////////////////////////////////////////////

// one access over the four-phase req/ack
task automatic host_access(input logic we, input logic imem, input rv_pkg::waddr_t addr,
                           input rv_pkg::word_t wdata, output rv_pkg::word_t rdata);
    int cycles;
    @(posedge clk);
    #1;
    i_host_req   = 1'b1;
    i_host_we    = we;
    i_host_imem  = imem;
    i_host_addr  = addr;
    i_host_wdata = wdata;
    cycles       = 0;
    do begin
        @(posedge clk);
        #1;
        cycles++;
    end while (!o_host_ack && cycles < ACK_LIMIT);
    assert (o_host_ack) else begin
        $display("host request at address %0d was never acknowledged", addr);
        $display("Some tests failed");
        $fatal(1);
    end
    rdata      = o_host_rdata;
    i_host_req = 1'b0;
    i_host_we  = 1'b0;
    cycles     = 0;
    do begin
        @(posedge clk);
        #1;
        cycles++;
    end while (o_host_ack && cycles < ACK_LIMIT);
    assert (!o_host_ack) else begin
        $display("host ack stayed high after the request was dropped");
        $display("Some tests failed");
        $fatal(1);
    end
endtask

task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
endtask

task automatic load_program();
    rv_pkg::word_t dummy;
    for (int i = 0; i < prog.size(); i++) begin
        host_access(1'b1, 1'b1, rv_pkg::waddr_t'(i), prog[i], dummy);
    end
endtask

task automatic run_program();
    int cycles;
    @(posedge clk);
    #1;
    i_run  = 1'b1;
    cycles = 0;
    do begin
        @(posedge clk);
        #1;
        cycles++;
    end while (!o_halted && cycles < RUN_LIMIT);
    assert (o_halted) else begin
        $display("core did not halt on ebreak");
        $display("Some tests failed");
        $fatal(1);
    end
    i_run = 1'b0;
endtask

// reads of words the program never touches
task automatic contend_host();
    rv_pkg::word_t  got;
    rv_pkg::waddr_t addr;
    for (int k = 0; k < HOST_READS; k++) begin
        addr = rv_pkg::waddr_t'(CONTEND_WORD + rand_bits(6));
        host_access(1'b0, 1'b0, addr, '0, got);
        check_word($sformatf("o_host_rdata dmem[%0d]", addr), got, model_dmem[addr]);
    end
endtask

task automatic check_results();
    rv_pkg::word_t got;
    for (int r = 0; r < 32; r++) begin
        host_access(1'b0, 1'b0, rv_pkg::waddr_t'(RESULT_WORD + r), '0, got);
        check_word($sformatf("o_host_rdata x%0d", r), got, model_dmem[RESULT_WORD + r]);
    end
    for (int w = 0; w < 64; w++) begin
        host_access(1'b0, 1'b0, rv_pkg::waddr_t'(w), '0, got);
        check_word($sformatf("o_host_rdata dmem[%0d]", w), got, model_dmem[w]);
    end
endtask

// seed area, contention area and random instruction words
task automatic test_memories();
    rv_pkg::word_t  got;
    rv_pkg::word_t  dummy;
    rv_pkg::word_t  iref [64];
    rv_pkg::waddr_t iaddr [64];
    for (int i = 0; i < 64; i++) begin
        model_dmem[i]                = rand_bits(32);
        model_dmem[CONTEND_WORD + i] = rand_bits(32);
        iref[i]                      = rand_bits(32);
        iaddr[i]                     = {6'(i), 8'(rand_bits(8))};
        host_access(1'b1, 1'b0, rv_pkg::waddr_t'(i), model_dmem[i], dummy);
        host_access(1'b1, 1'b0, rv_pkg::waddr_t'(CONTEND_WORD + i),
                    model_dmem[CONTEND_WORD + i], dummy);
        host_access(1'b1, 1'b1, iaddr[i], iref[i], dummy);
    end
    for (int i = 0; i < 64; i++) begin
        host_access(1'b0, 1'b0, rv_pkg::waddr_t'(i), '0, got);
        check_word($sformatf("o_host_rdata dmem[%0d]", i), got, model_dmem[i]);
        host_access(1'b0, 1'b0, rv_pkg::waddr_t'(CONTEND_WORD + i), '0, got);
        check_word($sformatf("o_host_rdata dmem[%0d]", CONTEND_WORD + i), got,
                   model_dmem[CONTEND_WORD + i]);
        host_access(1'b0, 1'b1, iaddr[i], '0, got);
        check_word($sformatf("o_host_rdata imem[%0d]", iaddr[i]), got, iref[i]);
    end
endtask

//////////////////////////////////////////////////////////////
// main sequence
//////////////////////////////////////////////////////////////
initial begin
    rst_n        = 1'b0;
    i_run        = 1'b0;
    i_host_req   = 1'b0;
    i_host_we    = 1'b0;
    i_host_imem  = 1'b0;
    i_host_addr  = '0;
    i_host_wdata = '0;
    lfsr         = SEED;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_memories();

    // each of the four program kinds runs twice
    for (int p = 0; p < N_PROGRAMS; p++) begin
        build_program(p % 4);
        run_model();
        apply_reset();
        load_program();
        if (p % 4 == 3) begin
            fork
                run_program();
                contend_host();
            join
        end else begin
            run_program();
        end
        check_results();
    end

    $display("All tests passed");
    $finish;
end

endmodule

// File: vlog.f
source/rv_pkg.sv
source/word_ram.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_core.sv
source/mem_arbiter.sv
source/rv_soc.sv
verification/tb_rv_soc.sv
